// ==== build.f ====
sms_pkg.sv
sms_port_decode.sv
sms_vdp_ctrl.sv
sms_mapper.sv
sms_read_mux.sv
sms_bus_glue.sv
tb_sms_bus_glue.sv

// ==== sms_bus_glue.sv ====
`default_nettype none

module sms_bus_glue (
  input  wire                              cpuClock,
  input  wire                              n_hard_reset,
  input  wire                              i_cpu_edge,
  // CPU bus
  input  wire [15:0]                       i_address,
  input  wire [7:0]                        i_data_out,
  input  wire                              i_n_rd,
  input  wire                              i_n_wr,
  input  wire                              i_n_iorq,
  input  wire                              i_n_mreq,
  output logic [7:0]                       o_cpu_data_in,
  // Memory and video sources
  input  wire [7:0]                        i_vram_dout,
  input  wire [7:0]                        i_bios_dout,
  input  wire [7:0]                        i_rom_dout,
  input  wire [7:0]                        i_ram_dout,
  input  wire [7:0]                        i_v_counter,
  input  wire [7:0]                        i_h_counter,
  input  wire [5:0]                        i_buttons,
  input  wire                              i_interrupt_flag,
  input  wire                              i_sprite_collision,
  input  wire                              i_too_many_sprites,
  input  wire [4:0]                        i_sprite5,
  // VDP side
  output logic [sms_pkg::VRAM_ADDR_W-1:0]  o_vram_addr,
  output logic                             o_vram_wr,
  output logic                             o_vram_rd,
  output logic                             o_cram_selected,
  output sms_pkg::vdp_cfg_t                o_vdp_cfg,
  // Memory side
  output logic [sms_pkg::ROM_ADDR_W-1:0]   o_rom_address,
  output logic                             o_ram_we,
  output logic                             o_psg_wr
);

  import sms_pkg::*;

  bus_access_t access;
  logic        bios_sel;

  sms_port_decode u_port_decode (
    .i_address  (i_address),
    .i_data_out (i_data_out),
    .i_n_rd     (i_n_rd),
    .i_n_wr     (i_n_wr),
    .i_n_iorq   (i_n_iorq),
    .i_n_mreq   (i_n_mreq),
    .o_access   (access)
  );

  sms_vdp_ctrl u_vdp_ctrl (
    .cpuClock        (cpuClock),
    .n_hard_reset    (n_hard_reset),
    .i_cpu_edge      (i_cpu_edge),
    .i_access        (access),
    .o_vram_addr     (o_vram_addr),
    .o_vram_wr       (o_vram_wr),
    .o_vram_rd       (o_vram_rd),
    .o_cram_selected (o_cram_selected),
    .o_vdp_cfg       (o_vdp_cfg)
  );

  sms_mapper u_mapper (
    .cpuClock      (cpuClock),
    .n_hard_reset  (n_hard_reset),
    .i_cpu_edge    (i_cpu_edge),
    .i_access      (access),
    .o_rom_address (o_rom_address),
    .o_ram_we      (o_ram_we),
    .o_bios_sel    (bios_sel),
    .o_psg_wr      (o_psg_wr)
  );

  sms_read_mux u_read_mux (
    .cpuClock           (cpuClock),
    .n_hard_reset       (n_hard_reset),
    .i_cpu_edge         (i_cpu_edge),
    .i_access           (access),
    .i_bios_sel         (bios_sel),
    .i_vram_dout        (i_vram_dout),
    .i_bios_dout        (i_bios_dout),
    .i_rom_dout         (i_rom_dout),
    .i_ram_dout         (i_ram_dout),
    .i_v_counter        (i_v_counter),
    .i_h_counter        (i_h_counter),
    .i_buttons          (i_buttons),
    .i_interrupt_flag   (i_interrupt_flag),
    .i_sprite_collision (i_sprite_collision),
    .i_too_many_sprites (i_too_many_sprites),
    .i_sprite5          (i_sprite5),
    .o_cpu_data_in      (o_cpu_data_in)
  );

endmodule

`default_nettype wire

// ==== sms_mapper.sv ====
`default_nettype none

module sms_mapper (
  input  wire                             cpuClock,
  input  wire                             n_hard_reset,
  input  wire                             i_cpu_edge,
  input  wire sms_pkg::bus_access_t       i_access,
  output logic [sms_pkg::ROM_ADDR_W-1:0]  o_rom_address,
  output logic                            o_ram_we,
  output logic                            o_bios_sel,
  output logic                            o_psg_wr
);

  import sms_pkg::*;

  logic [7:0] slot0;
  logic [7:0] slot1;
  logic [7:0] slot2;
  logic [7:0] r_mem_ctrl;

  always_ff @(posedge cpuClock) begin
    if (!n_hard_reset) begin
      slot0      <= 8'd0;
      slot1      <= 8'd1;
      slot2      <= 8'd2;
      r_mem_ctrl <= MEM_CTRL_RESET;
    end else if (i_cpu_edge) begin
      if (i_access.mem_wr) begin
        case (i_access.address)
          MAPPER_SLOT0_ADDR: slot0 <= i_access.data;
          MAPPER_SLOT1_ADDR: slot1 <= i_access.data;
          MAPPER_SLOT2_ADDR: slot2 <= i_access.data;
          default: ;
        endcase
      end
      if (i_access.io_wr && i_access.port == mem_ctrl) r_mem_ctrl <= i_access.data;
    end
  end

  // 16K pages, upper quarter is RAM and passes straight through
  always_comb begin
    case (i_access.address[15:14])
      2'd0:    o_rom_address = {slot0, i_access.address[13:0]};
      2'd1:    o_rom_address = {slot1, i_access.address[13:0]};
      2'd2:    o_rom_address = {slot2, i_access.address[13:0]};
      default: o_rom_address = {8'h00, i_access.address};
    endcase
  end

  assign o_ram_we   = i_access.mem_wr && i_access.address[15:14] == 2'b11;
  assign o_bios_sel = !r_mem_ctrl[3];
  assign o_psg_wr   = i_access.io_wr && i_access.port == psg;

endmodule

`default_nettype wire

// ==== sms_pkg.sv ====
`default_nettype none

package sms_pkg;

  // ====================
  // Port and bus types
  // ====================

  // I/O port picked by address bits 7:6 and 0
  typedef enum logic [3:0] {
    vdp_data,
    vdp_ctrl,
    psg,       // Write side of 0x41
    joy0,
    joy1,
    mem_ctrl,
    joy_ctrl,
    v_counter,
    h_counter  // Read side of 0x41
  } port_sel_t;

  // One CPU bus access, strobes already active high
  typedef struct packed {
    logic [15:0] address;
    logic [7:0]  data;
    port_sel_t   port;
    logic        io_rd;
    logic        io_wr;
    logic        mem_rd;
    logic        mem_wr;
  } bus_access_t;

  // ====================
  // VDP configuration
  // ====================

  typedef struct packed {
    logic [2:0]  mode;                // 0..4
    logic [13:0] name_base;
    logic [13:0] color_base;
    logic [13:0] font_base;
    logic [13:0] sprite_attr_base;
    logic [13:0] sprite_pattern_base;
    logic [3:0]  text_color;
    logic [3:0]  back_color;          // Also overscan
    logic [7:0]  x_scroll;
    logic [7:0]  y_scroll;
    logic [7:0]  line_counter;
    logic        video_on;
    logic        sprite_large;
    logic        sprite_enlarged;
    logic        vert_retrace_int;
    logic        disable_vert;        // Right columns not scrolled
    logic        disable_horiz;       // Top rows not scrolled
    logic        lines224;
    logic        lines240;
  } vdp_cfg_t;

  // ====================
  // Constants
  // ====================

  parameter int VDP_REG_COUNT = 11;
  parameter int VRAM_ADDR_W   = 14;
  parameter int ROM_ADDR_W    = 24;

  // Slot registers sit at the top of RAM space
  parameter logic [15:0] MAPPER_SLOT0_ADDR = 16'hfffd;
  parameter logic [15:0] MAPPER_SLOT1_ADDR = 16'hfffe;
  parameter logic [15:0] MAPPER_SLOT2_ADDR = 16'hffff;

  parameter logic [7:0] MEM_CTRL_RESET = 8'hf7; // Bit 3 clear, BIOS mapped in

endpackage

`default_nettype wire

// ==== sms_port_decode.sv ====
`default_nettype none

module sms_port_decode (
  input  wire [15:0]          i_address,
  input  wire [7:0]           i_data_out,
  input  wire                 i_n_rd,
  input  wire                 i_n_wr,
  input  wire                 i_n_iorq,
  input  wire                 i_n_mreq,
  output sms_pkg::bus_access_t o_access
);

  import sms_pkg::*;

  logic      io_rd;
  logic      io_wr;
  logic      mem_rd;
  logic      mem_wr;
  port_sel_t port;

  // Z80 strobes are active low, combine into request types
  assign io_rd  = !i_n_rd && !i_n_iorq;
  assign io_wr  = !i_n_wr && !i_n_iorq;
  assign mem_rd = !i_n_rd && !i_n_mreq;
  assign mem_wr = !i_n_wr && !i_n_mreq;

  // Only A7, A6 and A0 take part in port selection
  always_comb begin
    case ({i_address[7:6], i_address[0]})
      3'b000:  port = mem_ctrl;
      3'b001:  port = joy_ctrl;
      3'b010:  port = v_counter;
      3'b011:  port = io_wr ? psg : h_counter; // Shared address
      3'b100:  port = vdp_data;
      3'b101:  port = vdp_ctrl;
      3'b110:  port = joy0;
      default: port = joy1;
    endcase
  end

  always_comb begin
    o_access.address = i_address;
    o_access.data    = i_data_out;
    o_access.port    = port;
    o_access.io_rd   = io_rd;
    o_access.io_wr   = io_wr;
    o_access.mem_rd  = mem_rd;
    o_access.mem_wr  = mem_wr;
  end

  // The CPU never runs an I/O and a memory cycle at once
  always_comb begin
    assert #0 (!((io_rd || io_wr) && (mem_rd || mem_wr)))
      else $error("I/O and memory strobes active together");
  end

endmodule

`default_nettype wire

// ==== sms_read_mux.sv ====
`default_nettype none

module sms_read_mux (
  input  wire                       cpuClock,
  input  wire                       n_hard_reset,
  input  wire                       i_cpu_edge,
  input  wire sms_pkg::bus_access_t i_access,
  input  wire                       i_bios_sel,
  input  wire [7:0]                 i_vram_dout,
  input  wire [7:0]                 i_bios_dout,
  input  wire [7:0]                 i_rom_dout,
  input  wire [7:0]                 i_ram_dout,
  input  wire [7:0]                 i_v_counter,
  input  wire [7:0]                 i_h_counter,
  input  wire [5:0]                 i_buttons,
  input  wire                       i_interrupt_flag,
  input  wire                       i_sprite_collision,
  input  wire                       i_too_many_sprites,
  input  wire [4:0]                 i_sprite5,
  output logic [7:0]                o_cpu_data_in
);

  import sms_pkg::*;

  logic       r_int_flag;
  logic       r_coll_flag;
  logic       r_status_rd;
  logic       status_rd;
  logic [7:0] status;
  logic [7:0] joy_data;

  assign status_rd = i_access.io_rd && i_access.port == vdp_ctrl;

  // ====================
  // Status flags
  // ====================

  always_ff @(posedge cpuClock) begin
    if (!n_hard_reset) begin
      r_int_flag  <= 1'b0;
      r_coll_flag <= 1'b0;
      r_status_rd <= 1'b0;
    end else begin
      if (i_interrupt_flag) r_int_flag <= 1'b1;      // Set runs every clock
      if (i_sprite_collision) r_coll_flag <= 1'b1;
      if (i_cpu_edge) begin
        r_status_rd <= status_rd;
        // Clear beats a set once the status read is over
        if (r_status_rd && !status_rd) begin
          r_int_flag  <= 1'b0;
          r_coll_flag <= 1'b0;
        end
      end
    end
  end

  assign status = {r_int_flag, i_too_many_sprites, r_coll_flag,
                   (i_too_many_sprites ? i_sprite5 : 5'b11111)};

  // Top two bits stay zero above the six buttons
  assign joy_data = {2'b00, ~i_buttons[0], ~i_buttons[1], ~i_buttons[5:2]};

  // ====================
  // Read data select
  // ====================

  always_comb begin
    if (i_access.io_rd && i_access.port == vdp_data) o_cpu_data_in = i_vram_dout;
    else if (status_rd) o_cpu_data_in = status;
    else if (i_access.io_rd && (i_access.port == joy0 || i_access.port == joy1))
      o_cpu_data_in = joy_data;
    else if (i_access.io_rd && i_access.port == v_counter) o_cpu_data_in = i_v_counter;
    else if (i_access.io_rd && i_access.port == h_counter) o_cpu_data_in = i_h_counter;
    else if (i_access.mem_rd && i_access.address[15:14] != 2'b11)
      o_cpu_data_in = i_bios_sel ? i_bios_dout : i_rom_dout;
    else o_cpu_data_in = i_ram_dout; // RAM is also the idle value
  end

endmodule

`default_nettype wire

// ==== sms_vdp_ctrl.sv ====
`default_nettype none

module sms_vdp_ctrl (
  input  wire                              cpuClock,
  input  wire                              n_hard_reset,
  input  wire                              i_cpu_edge,
  input  wire sms_pkg::bus_access_t        i_access,
  output logic [sms_pkg::VRAM_ADDR_W-1:0]  o_vram_addr,
  output logic                             o_vram_wr,
  output logic                             o_vram_rd,
  output logic                             o_cram_selected,
  output sms_pkg::vdp_cfg_t                o_vdp_cfg
);

  import sms_pkg::*;

  logic [7:0] r_vdp [0:VDP_REG_COUNT-1];
  logic [7:0] first_byte;
  logic       second_byte;   // Next control write completes the pair
  logic       r_data_rd;     // Data read seen at previous edge
  logic       data_wr;
  logic       data_rd;
  logic       ctrl_wr;
  logic       ctrl_rd;
  logic       m1, m2, m3, m4;
  logic [2:0] mode;

  assign data_wr = i_access.io_wr && i_access.port == vdp_data;
  assign data_rd = i_access.io_rd && i_access.port == vdp_data;
  assign ctrl_wr = i_access.io_wr && i_access.port == vdp_ctrl;
  assign ctrl_rd = i_access.io_rd && i_access.port == vdp_ctrl;

  assign o_vram_wr = data_wr && i_cpu_edge;
  assign o_vram_rd = data_rd && i_cpu_edge;

  // ====================
  // Control port
  // ====================

  always_ff @(posedge cpuClock) begin
    if (!n_hard_reset) begin
      for (int i = 0; i < VDP_REG_COUNT; i++) begin
        r_vdp[i] <= 8'h00;
      end
      o_vram_addr     <= '0;
      o_cram_selected <= 1'b0;
      second_byte     <= 1'b0;
      r_data_rd       <= 1'b0;
    end else if (i_cpu_edge) begin
      r_data_rd <= data_rd;
      if (data_wr) o_vram_addr <= o_vram_addr + 1'b1;
      if (r_data_rd && !data_rd) o_vram_addr <= o_vram_addr + 1'b1; // Read has ended

      if (ctrl_rd || data_rd || data_wr) second_byte <= 1'b0;

      if (ctrl_wr) begin
        second_byte <= !second_byte;
        if (second_byte) begin
          if (!i_access.data[7]) begin
            // VRAM address, bit 6 (read/write intent) ignored
            o_vram_addr     <= {i_access.data[5:0], first_byte};
            o_cram_selected <= 1'b0;
          end else if (i_access.data[7:6] == 2'b10 &&
                       int'(i_access.data[3:0]) < VDP_REG_COUNT) begin
            r_vdp[i_access.data[3:0]] <= first_byte;
          end else begin
            // Code 3, and unknown register indexes
            o_vram_addr     <= {8'h00, first_byte[5:0]};
            o_cram_selected <= 1'b1;
          end
        end
      end
    end
  end

  // First byte of the pair
  always_ff @(posedge cpuClock) begin
    if (i_cpu_edge && ctrl_wr && !second_byte) first_byte <= i_access.data;
  end

  // ====================
  // Register decode
  // ====================

  assign m1 = r_vdp[1][4];
  assign m2 = r_vdp[0][1];
  assign m3 = r_vdp[1][3];
  assign m4 = r_vdp[0][2];

  assign mode = m4 ? 3'd4 : m3 ? 3'd3 : m2 ? 3'd2 : m1 ? 3'd1 : 3'd0;

  always_comb begin
    o_vdp_cfg.mode       = mode;
    o_vdp_cfg.name_base  = {r_vdp[2][3:1], 11'b0};
    o_vdp_cfg.color_base = (mode == 3'd2) ? {r_vdp[3][7], 13'b0} : {r_vdp[3], 6'b0};
    if (mode == 3'd4) o_vdp_cfg.font_base = '0;
    else if (mode == 3'd2) o_vdp_cfg.font_base = {r_vdp[4][2], 13'b0};
    else o_vdp_cfg.font_base = {r_vdp[4][2:0], 11'b0};
    o_vdp_cfg.sprite_attr_base    = {r_vdp[5][6:1], 8'b0};
    o_vdp_cfg.sprite_pattern_base = (mode == 3'd4) ? {r_vdp[6][2], 13'b0}
                                                   : {r_vdp[6][2:0], 11'b0};
    o_vdp_cfg.text_color       = r_vdp[7][7:4];
    o_vdp_cfg.back_color       = r_vdp[7][3:0];
    o_vdp_cfg.x_scroll         = r_vdp[8];
    o_vdp_cfg.y_scroll         = r_vdp[9];
    o_vdp_cfg.line_counter     = r_vdp[10];
    o_vdp_cfg.video_on         = r_vdp[1][6];
    o_vdp_cfg.sprite_large     = r_vdp[1][1];
    o_vdp_cfg.sprite_enlarged  = r_vdp[1][0];
    o_vdp_cfg.vert_retrace_int = r_vdp[1][5];
    o_vdp_cfg.disable_vert     = r_vdp[0][7];
    o_vdp_cfg.disable_horiz    = r_vdp[0][6];
    o_vdp_cfg.lines224         = m2 & m1;
    o_vdp_cfg.lines240         = m2 & m3;
  end

  // Bus decode upstream must never yield both strobes
  assert property (@(posedge cpuClock) disable iff (!n_hard_reset)
                   !(o_vram_wr && o_vram_rd))
    else $error("VRAM write and read pulse together");

endmodule

`default_nettype wire

// ==== tb_sms_bus_glue.sv ====
`default_nettype none

module tb_sms_bus_glue;

  import sms_pkg::*;

  localparam int NUM_CYCLES   = 4000;
  localparam int RESET_CYCLES = 5;
  localparam int WAIT_LIMIT   = 20;

  logic                   cpuClock;
  logic                   n_hard_reset;
  logic                   i_cpu_edge;
  logic [15:0]            i_address;
  logic [7:0]             i_data_out;
  logic                   i_n_rd;
  logic                   i_n_wr;
  logic                   i_n_iorq;
  logic                   i_n_mreq;
  logic [7:0]             o_cpu_data_in;
  logic [7:0]             i_vram_dout;
  logic [7:0]             i_bios_dout;
  logic [7:0]             i_rom_dout;
  logic [7:0]             i_ram_dout;
  logic [7:0]             i_v_counter;
  logic [7:0]             i_h_counter;
  logic [5:0]             i_buttons;
  logic                   i_interrupt_flag;
  logic                   i_sprite_collision;
  logic                   i_too_many_sprites;
  logic [4:0]             i_sprite5;
  logic [VRAM_ADDR_W-1:0] o_vram_addr;
  logic                   o_vram_wr;
  logic                   o_vram_rd;
  logic                   o_cram_selected;
  vdp_cfg_t               o_vdp_cfg;
  logic [ROM_ADDR_W-1:0]  o_rom_address;
  logic                   o_ram_we;
  logic                   o_psg_wr;

  // Reference model state
  logic [7:0]  exp_regs [0:10];
  logic [7:0]  exp_first;
  logic        exp_second;
  logic        exp_data_rd_prev;
  logic [13:0] exp_vram_addr;
  logic        exp_cram;
  logic [7:0]  exp_slot [0:2];
  logic [7:0]  exp_mem_ctrl;
  logic        exp_int;
  logic        exp_coll;
  logic        exp_status_rd_prev;

  int error_count;
  int seed_result;
  int wait_count;

  sms_bus_glue u_sms_bus_glue (
    .cpuClock           (cpuClock),
    .n_hard_reset       (n_hard_reset),
    .i_cpu_edge         (i_cpu_edge),
    .i_address          (i_address),
    .i_data_out         (i_data_out),
    .i_n_rd             (i_n_rd),
    .i_n_wr             (i_n_wr),
    .i_n_iorq           (i_n_iorq),
    .i_n_mreq           (i_n_mreq),
    .o_cpu_data_in      (o_cpu_data_in),
    .i_vram_dout        (i_vram_dout),
    .i_bios_dout        (i_bios_dout),
    .i_rom_dout         (i_rom_dout),
    .i_ram_dout         (i_ram_dout),
    .i_v_counter        (i_v_counter),
    .i_h_counter        (i_h_counter),
    .i_buttons          (i_buttons),
    .i_interrupt_flag   (i_interrupt_flag),
    .i_sprite_collision (i_sprite_collision),
    .i_too_many_sprites (i_too_many_sprites),
    .i_sprite5          (i_sprite5),
    .o_vram_addr        (o_vram_addr),
    .o_vram_wr          (o_vram_wr),
    .o_vram_rd          (o_vram_rd),
    .o_cram_selected    (o_cram_selected),
    .o_vdp_cfg          (o_vdp_cfg),
    .o_rom_address      (o_rom_address),
    .o_ram_we           (o_ram_we),
    .o_psg_wr           (o_psg_wr)
  );

  always #2 cpuClock = ~cpuClock;

  task automatic report_mismatch(input string what, input logic [127:0] expv,
                                 input logic [127:0] gotv);
    error_count++;
    $display("Mismatch at time %0t: %s expected %0h, got %0h", $time, what, expv, gotv);
    $display("Checks failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic reset_model();
    for (int i = 0; i < 11; i++) begin
      exp_regs[i] = 8'h00;
    end
    exp_first          = 8'h00;
    exp_second         = 1'b0;
    exp_data_rd_prev   = 1'b0;
    exp_vram_addr      = 14'd0;
    exp_cram           = 1'b0;
    exp_slot[0]        = 8'd0;
    exp_slot[1]        = 8'd1;
    exp_slot[2]        = 8'd2;
    exp_mem_ctrl       = 8'hf7;
    exp_int            = 1'b0;
    exp_coll           = 1'b0;
    exp_status_rd_prev = 1'b0;
  endtask

  // ====================
  // Stimulus
  // ====================

  task automatic drive_random();
    int          kind;
    logic [15:0] addr;
    logic [7:0]  data;
    i_cpu_edge = ($urandom % 3) == 0;
    i_n_rd     = 1'b1;
    i_n_wr     = 1'b1;
    i_n_iorq   = 1'b1;
    i_n_mreq   = 1'b1;
    kind = $urandom % 10;
    addr = 16'($urandom);
    data = 8'($urandom);
    if (kind < 5) begin                         // I/O cycle
      if ($urandom % 3 != 0) addr[7:6] = 2'b10; // Mostly VDP ports
      if ($urandom % 4 != 0) data[7] = 1'b1;    // Favor register and CRAM codes
      i_n_iorq = 1'b0;
      if ($urandom % 2) i_n_wr = 1'b0;
      else i_n_rd = 1'b0;
    end else if (kind < 8) begin                // Memory cycle
      if ($urandom % 3 == 0) addr = 16'hfffd + 16'($urandom % 3);
      i_n_mreq = 1'b0;
      if ($urandom % 2) i_n_wr = 1'b0;
      else i_n_rd = 1'b0;
    end
    i_address          = addr;
    i_data_out         = data;
    i_vram_dout        = 8'($urandom);
    i_bios_dout        = 8'($urandom);
    i_rom_dout         = 8'($urandom);
    i_ram_dout         = 8'($urandom);
    i_v_counter        = 8'($urandom);
    i_h_counter        = 8'($urandom);
    i_buttons          = 6'($urandom);
    i_interrupt_flag   = ($urandom % 8) == 0;
    i_sprite_collision = ($urandom % 8) == 0;
    i_too_many_sprites = ($urandom % 4) == 0;
    i_sprite5          = 5'($urandom);
  endtask

  // ====================
  // Reference model
  // ====================

  function automatic logic [7:0] expected_read_data();
    logic       io_rd;
    logic       mem_rd;
    logic [2:0] sel;
    logic [7:0] status;
    io_rd  = !i_n_rd && !i_n_iorq;
    mem_rd = !i_n_rd && !i_n_mreq;
    sel    = {i_address[7:6], i_address[0]};
    status = {exp_int, i_too_many_sprites, exp_coll,
              (i_too_many_sprites ? i_sprite5 : 5'h1f)};
    if (io_rd && sel == 3'b100) return i_vram_dout;
    if (io_rd && sel == 3'b101) return status;
    if (io_rd && sel[2:1] == 2'b11)
      return {2'b00, ~i_buttons[0], ~i_buttons[1], ~i_buttons[5], ~i_buttons[4],
              ~i_buttons[3], ~i_buttons[2]};
    if (io_rd && sel == 3'b010) return i_v_counter;
    if (io_rd && sel == 3'b011) return i_h_counter;
    if (mem_rd && i_address < 16'hc000)
      return exp_mem_ctrl[3] ? i_rom_dout : i_bios_dout; // Bit 3 set unmaps BIOS
    return i_ram_dout;
  endfunction

  function automatic vdp_cfg_t expected_cfg();
    vdp_cfg_t    c;
    logic        m1, m2, m3, m4;
    logic [13:0] t;
    m1 = exp_regs[1][4];
    m2 = exp_regs[0][1];
    m3 = exp_regs[1][3];
    m4 = exp_regs[0][2];
    if (m4) c.mode = 3'd4;
    else if (m3) c.mode = 3'd3;
    else if (m2) c.mode = 3'd2;
    else if (m1) c.mode = 3'd1;
    else c.mode = 3'd0;
    c.name_base = {exp_regs[2][3:1], 11'd0};
    t = {6'd0, exp_regs[3]};
    c.color_base = (c.mode == 3'd2) ? {exp_regs[3][7], 13'd0} : (t << 6);
    t = {6'd0, exp_regs[4]};
    if (c.mode == 3'd4) c.font_base = 14'd0;
    else if (c.mode == 3'd2) c.font_base = {exp_regs[4][2], 13'd0};
    else c.font_base = t << 11;
    c.sprite_attr_base = {exp_regs[5][6:1], 8'd0};
    t = {6'd0, exp_regs[6]};
    c.sprite_pattern_base = (c.mode == 3'd4) ? {exp_regs[6][2], 13'd0} : (t << 11);
    c.text_color       = exp_regs[7][7:4];
    c.back_color       = exp_regs[7][3:0];
    c.x_scroll         = exp_regs[8];
    c.y_scroll         = exp_regs[9];
    c.line_counter     = exp_regs[10];
    c.video_on         = exp_regs[1][6];
    c.vert_retrace_int = exp_regs[1][5];
    c.sprite_large     = exp_regs[1][1];
    c.sprite_enlarged  = exp_regs[1][0];
    c.disable_vert     = exp_regs[0][7];
    c.disable_horiz    = exp_regs[0][6];
    c.lines224         = m2 && m1;
    c.lines240         = m2 && m3;
    return c;
  endfunction

  task automatic check_outputs();
    logic [2:0]  sel;
    logic        io_rd, io_wr, mem_wr;
    logic [23:0] rom_addr;
    logic [7:0]  rd_data;
    logic        ram_we;
    logic        psg_wr;
    logic        vram_wr;
    logic        vram_rd;
    vdp_cfg_t    cfg;
    sel     = {i_address[7:6], i_address[0]};
    io_rd   = !i_n_rd && !i_n_iorq;
    io_wr   = !i_n_wr && !i_n_iorq;
    mem_wr  = !i_n_wr && !i_n_mreq;
    rd_data = expected_read_data();
    cfg     = expected_cfg();
    ram_we  = mem_wr && i_address[15:14] == 2'b11;
    psg_wr  = io_wr && sel == 3'b011;
    vram_wr = io_wr && sel == 3'b100 && i_cpu_edge;
    vram_rd = io_rd && sel == 3'b100 && i_cpu_edge;
    if (i_address[15:14] == 2'b11) rom_addr = {8'h00, i_address};
    else rom_addr = {exp_slot[i_address[15:14]], i_address[13:0]};
    assert (o_cpu_data_in === rd_data)
      else report_mismatch("o_cpu_data_in", rd_data, o_cpu_data_in);
    assert (o_rom_address === rom_addr)
      else report_mismatch("o_rom_address", rom_addr, o_rom_address);
    assert (o_ram_we === ram_we)
      else report_mismatch("o_ram_we", ram_we, o_ram_we);
    assert (o_psg_wr === psg_wr)
      else report_mismatch("o_psg_wr", psg_wr, o_psg_wr);
    assert (o_vram_wr === vram_wr)
      else report_mismatch("o_vram_wr", vram_wr, o_vram_wr);
    assert (o_vram_rd === vram_rd)
      else report_mismatch("o_vram_rd", vram_rd, o_vram_rd);
    assert (o_vram_addr === exp_vram_addr)
      else report_mismatch("o_vram_addr", exp_vram_addr, o_vram_addr);
    assert (o_cram_selected === exp_cram)
      else report_mismatch("o_cram_selected", exp_cram, o_cram_selected);
    assert (o_vdp_cfg === cfg)
      else report_mismatch("o_vdp_cfg", cfg, o_vdp_cfg);
  endtask

  // Next state from the inputs held over a rising edge
  task automatic update_model();
    logic [2:0] sel;
    logic       io_rd, io_wr, mem_wr;
    logic       data_rd, data_wr, ctrl_rd, ctrl_wr;
    logic [7:0] d;
    sel     = {i_address[7:6], i_address[0]};
    io_rd   = !i_n_rd && !i_n_iorq;
    io_wr   = !i_n_wr && !i_n_iorq;
    mem_wr  = !i_n_wr && !i_n_mreq;
    data_rd = io_rd && sel == 3'b100;
    data_wr = io_wr && sel == 3'b100;
    ctrl_rd = io_rd && sel == 3'b101;
    ctrl_wr = io_wr && sel == 3'b101;
    d       = i_data_out;
    if (i_interrupt_flag) exp_int = 1'b1;   // Sets need no edge
    if (i_sprite_collision) exp_coll = 1'b1;
    if (i_cpu_edge) begin
      if (exp_status_rd_prev && !ctrl_rd) begin
        exp_int  = 1'b0;
        exp_coll = 1'b0;
      end
      exp_status_rd_prev = ctrl_rd;
      if (data_wr || (exp_data_rd_prev && !data_rd)) exp_vram_addr = exp_vram_addr + 14'd1;
      exp_data_rd_prev = data_rd;
      if (ctrl_rd || data_rd || data_wr) exp_second = 1'b0;
      if (ctrl_wr && !exp_second) begin
        exp_first  = d;
        exp_second = 1'b1;
      end else if (ctrl_wr) begin
        exp_second = 1'b0;
        if (!d[7]) begin
          exp_vram_addr = {d[5:0], exp_first};
          exp_cram      = 1'b0;
        end else if (d[7:6] == 2'b10 && d[3:0] < 4'd11) begin
          exp_regs[d[3:0]] = exp_first;
        end else begin
          exp_vram_addr = {8'h00, exp_first[5:0]};
          exp_cram      = 1'b1;
        end
      end
      if (mem_wr && i_address >= 16'hfffd) exp_slot[i_address - 16'hfffd] = d;
      if (io_wr && sel == 3'b000) exp_mem_ctrl = d;
    end
  endtask

  // ====================
  // Main sequence
  // ====================

  initial begin
    cpuClock           = 1'b0;
    n_hard_reset       = 1'b0;
    i_cpu_edge         = 1'b0;
    i_address          = 16'h0000;
    i_data_out         = 8'h00;
    i_n_rd             = 1'b1;
    i_n_wr             = 1'b1;
    i_n_iorq           = 1'b1;
    i_n_mreq           = 1'b1;
    i_vram_dout        = 8'h00;
    i_bios_dout        = 8'h00;
    i_rom_dout         = 8'h00;
    i_ram_dout         = 8'h00;
    i_v_counter        = 8'h00;
    i_h_counter        = 8'h00;
    i_buttons          = 6'h00;
    i_interrupt_flag   = 1'b0;
    i_sprite_collision = 1'b0;
    i_too_many_sprites = 1'b0;
    i_sprite5          = 5'h00;
    error_count        = 0;
    seed_result        = $urandom(32'h2d4e_2c52);
    reset_model();

    for (int n = 0; n < RESET_CYCLES; n++) begin
      @(posedge cpuClock);
    end
    @(negedge cpuClock);
    n_hard_reset = 1'b1;

    // DUT should sit in its reset state before random traffic
    wait_count = 0;
    while (o_vram_addr !== 14'd0 || o_cram_selected !== 1'b0) begin
      @(posedge cpuClock);
      wait_count++;
      if (wait_count > WAIT_LIMIT) begin
        $display("Timeout: DUT did not show its reset state after reset release");
        $display("Checks failed");
        $fatal(1, "reset wait timed out");
      end
    end

    for (int n = 0; n < NUM_CYCLES; n++) begin
      @(negedge cpuClock);
      drive_random();
      #1;
      check_outputs();
      @(posedge cpuClock);
      update_model();
    end

    if (error_count == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
